// File: rtl/cmd_sequencer.sv
`timescale 1ns/10ps

module cmd_sequencer import sdram_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  sdram_req_t  head,
    input  logic        head_valid,
    output logic        pop,
    input  row_state_t  row_state,
    output bank_addr_t  lookup_bank,
    output row_addr_t   lookup_row,
    output logic        mark_open,
    output bank_addr_t  open_bank,
    output row_addr_t   open_row,
    output logic        close_bank,
    output bank_addr_t  close_bank_sel,
    output logic        close_all,
    output sdram_pins_t pins,
    input  sdram_word_t sdram_dqi,
    output sdram_word_t rd_data,
    output logic        rd_valid
);

    seq_state_t  state, state_d;
    seq_state_t  ret_state, ret_state_d;    // where ST_WAIT goes next
    logic [2:0]  delay_cnt, delay_cnt_d;
    sdram_req_t  cur_req, cur_req_d;
    logic        pre_all, pre_all_d;        // precharge all banks for refresh
    sdram_pins_t pins_d;

    logic [$clog2(REFRESH_INTERVAL)-1:0] refresh_cnt;
    logic        refresh_pending;
    logic        take_refresh;
    logic        rd_capture;
    sdram_word_t dqi_q;

    assign lookup_bank = addr_bank(head.addr);
    assign lookup_row  = addr_row(head.addr);

    // row tracker updates follow the command being issued
    assign mark_open      = (state == ST_ACTIVATE);
    assign open_bank      = addr_bank(cur_req.addr);
    assign open_row       = addr_row(cur_req.addr);
    assign close_bank     = (state == ST_PRECHARGE) && !pre_all;
    assign close_bank_sel = addr_bank(cur_req.addr);
    assign close_all      = (state == ST_PRECHARGE) && pre_all;

    always_comb begin
        state_d     = state;
        ret_state_d = ret_state;
        delay_cnt_d = delay_cnt;
        cur_req_d   = cur_req;
        pre_all_d   = pre_all;
        pop          = 1'b0;
        take_refresh = 1'b0;
        rd_capture   = 1'b0;

        pins_d.cke    = 1'b1;
        pins_d.cmd    = CMD_NOP;
        pins_d.ba     = addr_bank(cur_req.addr);
        pins_d.a      = '0;
        pins_d.dq_out = cur_req.data;
        pins_d.dq_oe  = 1'b0;

        case (state)
            ST_IDLE: begin
                if (refresh_pending) begin
                    // close everything before refresh
                    take_refresh = 1'b1;
                    pre_all_d    = 1'b1;
                    ret_state_d  = ST_REFRESH;
                    state_d      = ST_PRECHARGE;
                end else if (head_valid) begin
                    pop       = 1'b1;
                    cur_req_d = head;
                    pre_all_d = 1'b0;
                    case (row_state)
                        ROW_HIT: begin
                            state_d = head.write ? ST_WRITE : ST_READ;
                        end
                        ROW_CONFLICT: begin
                            ret_state_d = ST_ACTIVATE;
                            state_d     = ST_PRECHARGE;
                        end
                        default: begin
                            state_d = ST_ACTIVATE;   // bank closed
                        end
                    endcase
                end
            end

            ST_PRECHARGE: begin
                pins_d.cmd        = CMD_PRECHARGE;
                pins_d.a[AP_BIT]  = pre_all;
                delay_cnt_d       = 3'(T_RP - 2);
                state_d           = ST_WAIT;
            end

            ST_REFRESH: begin
                pins_d.cmd  = CMD_REFRESH;
                delay_cnt_d = 3'(T_RFC - 2);
                ret_state_d = ST_IDLE;
                state_d     = ST_WAIT;
            end

            ST_ACTIVATE: begin
                pins_d.cmd  = CMD_ACTIVE;
                pins_d.a    = addr_row(cur_req.addr);
                delay_cnt_d = 3'(T_RCD - 2);
                ret_state_d = cur_req.write ? ST_WRITE : ST_READ;
                state_d     = ST_WAIT;
            end

            ST_READ: begin
                pins_d.cmd      = CMD_READ;
                pins_d.a[9:2]   = addr_col(cur_req.addr);
                // two extra cycles for the dqi register and capture
                delay_cnt_d     = 3'(CAS_LATENCY);
                ret_state_d     = ST_READ_CAPTURE;
                state_d         = ST_WAIT;
            end

            ST_WRITE: begin
                pins_d.cmd      = CMD_WRITE;
                pins_d.a[9:2]   = addr_col(cur_req.addr);
                pins_d.dq_oe    = 1'b1;     // data goes out with the command
                delay_cnt_d     = 3'(WRITE_RECOVERY - 2);
                ret_state_d     = ST_IDLE;
                state_d         = ST_WAIT;
            end

            ST_WAIT: begin
                if (delay_cnt == '0) begin
                    state_d = ret_state;
                end else begin
                    delay_cnt_d = delay_cnt - 1'b1;
                end
            end

            ST_READ_CAPTURE: begin
                rd_capture = 1'b1;
                state_d    = ST_IDLE;
            end

            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            ret_state <= ST_IDLE;
            delay_cnt <= '0;
            pre_all   <= 1'b0;
        end else begin
            state     <= state_d;
            ret_state <= ret_state_d;
            delay_cnt <= delay_cnt_d;
            pre_all   <= pre_all_d;
        end
        cur_req <= cur_req_d;
    end

    // refresh timer, a new tick wins over the clear
    always_ff @(posedge clk) begin
        if (rst) begin
            refresh_cnt     <= '0;
            refresh_pending <= 1'b0;
        end else begin
            if (refresh_cnt == REFRESH_INTERVAL - 1) begin
                refresh_cnt     <= '0;
                refresh_pending <= 1'b1;
            end else begin
                refresh_cnt <= refresh_cnt + 1'b1;
                if (take_refresh) begin
                    refresh_pending <= 1'b0;
                end
            end
        end
    end

    // pin registers, cke held low only during reset
    always_ff @(posedge clk) begin
        if (rst) begin
            pins.cke   <= 1'b0;
            pins.cmd   <= CMD_NOP;
            pins.dq_oe <= 1'b0;
        end else begin
            pins.cke   <= pins_d.cke;
            pins.cmd   <= pins_d.cmd;
            pins.dq_oe <= pins_d.dq_oe;
        end
        pins.ba     <= pins_d.ba;
        pins.a      <= pins_d.a;
        pins.dq_out <= pins_d.dq_out;
    end

    // read data path
    always_ff @(posedge clk) begin
        dqi_q <= sdram_dqi;
        if (rd_capture) begin
            rd_data <= dqi_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_capture;
        end
    end

endmodule

// File: rtl/req_queue.sv
`timescale 1ns/10ps

module req_queue import sdram_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       push,
    input  sdram_req_t push_req,
    input  logic       pop,
    output sdram_req_t head,
    output logic       head_valid,
    output logic       credit_return
);

    sdram_req_t                       entries [QUEUE_DEPTH];
    logic [$clog2(QUEUE_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(QUEUE_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(QUEUE_DEPTH):0]     count;    // one extra bit for full
    logic                             pop_ok;

    // credits keep occupancy at or below depth, so push never sees a full queue
    assign pop_ok     = pop && head_valid;
    assign head_valid = (count != '0);
    assign head       = entries[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_req;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;    // wraps, depth is a power of two
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({push, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // none, or push and pop together
            endcase
        end
    end

    // one credit back per request handed to the sequencer
    always_ff @(posedge clk) begin
        if (rst) begin
            credit_return <= 1'b0;
        end else begin
            credit_return <= pop_ok;
        end
    end

endmodule

// File: rtl/row_tracker.sv
`timescale 1ns/10ps

module row_tracker import sdram_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  bank_addr_t lookup_bank,
    input  row_addr_t  lookup_row,
    output row_state_t row_state,
    input  logic       mark_open,
    input  bank_addr_t open_bank,
    input  row_addr_t  open_row,
    input  logic       close_bank,
    input  bank_addr_t close_bank_sel,
    input  logic       close_all
);

    logic [(1 << $bits(bank_addr_t))-1:0] open_flags;   // one per bank
    row_addr_t open_rows [1 << $bits(bank_addr_t)];

    // classify the lookup against the open row of its bank
    always_comb begin
        if (!open_flags[lookup_bank]) begin
            row_state = ROW_CLOSED;
        end else if (open_rows[lookup_bank] == lookup_row) begin
            row_state = ROW_HIT;
        end else begin
            row_state = ROW_CONFLICT;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            open_flags <= '0;
        end else begin
            if (close_all) begin
                open_flags <= '0;
            end else begin
                if (close_bank) begin
                    open_flags[close_bank_sel] <= 1'b0;
                end
                if (mark_open) begin
                    open_flags[open_bank] <= 1'b1;
                end
            end
        end
    end

    // row address only meaningful while its flag is set
    always_ff @(posedge clk) begin
        if (mark_open) begin
            open_rows[open_bank] <= open_row;
        end
    end

endmodule

// File: rtl/sdram_ctrl.sv
`timescale 1ns/10ps

module sdram_ctrl import sdram_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        req_valid,
    input  sdram_req_t  req,
    output logic        credit_return,
    output sdram_word_t rd_data,
    output logic        rd_valid,
    output sdram_pins_t pins,
    input  sdram_word_t sdram_dqi
);

    sdram_req_t head;
    logic       head_valid;
    logic       pop;

    row_state_t row_state;
    bank_addr_t lookup_bank;
    row_addr_t  lookup_row;
    logic       mark_open;
    bank_addr_t open_bank;
    row_addr_t  open_row;
    logic       close_bank;
    bank_addr_t close_bank_sel;
    logic       close_all;

    // every valid request spends a credit, so it is always pushed
    req_queue i_req_queue (
        .clk           (clk),
        .rst           (rst),
        .push          (req_valid),
        .push_req      (req),
        .pop           (pop),
        .head          (head),
        .head_valid    (head_valid),
        .credit_return (credit_return)
    );

    cmd_sequencer i_cmd_sequencer (
        .clk            (clk),
        .rst            (rst),
        .head           (head),
        .head_valid     (head_valid),
        .pop            (pop),
        .row_state      (row_state),
        .lookup_bank    (lookup_bank),
        .lookup_row     (lookup_row),
        .mark_open      (mark_open),
        .open_bank      (open_bank),
        .open_row       (open_row),
        .close_bank     (close_bank),
        .close_bank_sel (close_bank_sel),
        .close_all      (close_all),
        .pins           (pins),
        .sdram_dqi      (sdram_dqi),
        .rd_data        (rd_data),
        .rd_valid       (rd_valid)
    );

    row_tracker i_row_tracker (
        .clk            (clk),
        .rst            (rst),
        .lookup_bank    (lookup_bank),
        .lookup_row     (lookup_row),
        .row_state      (row_state),
        .mark_open      (mark_open),
        .open_bank      (open_bank),
        .open_row       (open_row),
        .close_bank     (close_bank),
        .close_bank_sel (close_bank_sel),
        .close_all      (close_all)
    );

endmodule

// File: rtl/sdram_pkg.sv
package sdram_pkg;

    localparam int QUEUE_DEPTH      = 4;
    localparam int T_RP             = 3;    // precharge to next command
    localparam int T_RCD            = 3;    // active to read/write
    localparam int T_RFC            = 7;    // refresh to next command
    localparam int CAS_LATENCY      = 3;
    localparam int WRITE_RECOVERY   = 3;
    localparam int REFRESH_INTERVAL = 752;
    localparam int AP_BIT           = 10;   // all-bank precharge select

    typedef logic [12:0] row_addr_t;
    typedef logic [1:0]  bank_addr_t;
    typedef logic [7:0]  col_addr_t;
    typedef logic [22:0] user_addr_t;   // {row, bank, col}
    typedef logic [31:0] sdram_word_t;

    // {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        CMD_NOP       = 4'b0111,
        CMD_ACTIVE    = 4'b0011,
        CMD_READ      = 4'b0101,
        CMD_WRITE     = 4'b0100,
        CMD_PRECHARGE = 4'b0010,
        CMD_REFRESH   = 4'b0001
    } sdram_cmd_t;

    typedef struct packed {
        logic        write;     // 1 = write, 0 = read
        user_addr_t  addr;
        sdram_word_t data;      // write payload
    } sdram_req_t;

    typedef struct packed {
        logic        cke;
        sdram_cmd_t  cmd;
        bank_addr_t  ba;
        logic [12:0] a;
        sdram_word_t dq_out;
        logic        dq_oe;
    } sdram_pins_t;

    typedef enum logic [1:0] {
        ROW_CLOSED,
        ROW_HIT,
        ROW_CONFLICT
    } row_state_t;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_PRECHARGE,
        ST_REFRESH,
        ST_ACTIVATE,
        ST_READ,
        ST_WRITE,
        ST_WAIT,
        ST_READ_CAPTURE
    } seq_state_t;

    // address field split
    function automatic row_addr_t addr_row(input user_addr_t addr);
        return addr[22:10];
    endfunction

    function automatic bank_addr_t addr_bank(input user_addr_t addr);
        return addr[9:8];
    endfunction

    function automatic col_addr_t addr_col(input user_addr_t addr);
        return addr[7:0];
    endfunction

endpackage

// File: sim.f
rtl/sdram_pkg.sv
rtl/req_queue.sv
rtl/row_tracker.sv
rtl/cmd_sequencer.sv
rtl/sdram_ctrl.sv
verification/sdram_model.sv
verification/sdram_checker.sv
verification/tb_sdram_ctrl.sv

// File: verification/sdram_checker.sv
`timescale 1ns/10ps

module sdram_checker import sdram_pkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        req_valid,
    input logic        credit_return,
    input logic        rd_valid,
    input sdram_pins_t pins
);

    int unsigned fail_count = 0;
    logic [3:0]  outstanding;       // requests not yet credited back
    int unsigned since_refresh;
    logic        warm;              // first edge seen

    always @(posedge clk) begin
        warm <= 1'b1;
        if (rst) begin
            outstanding   <= '0;
            since_refresh <= 0;
        end else begin
            outstanding   <= outstanding + 4'(req_valid) - 4'(credit_return);
            since_refresh <= (pins.cmd == CMD_REFRESH) ? 0 : since_refresh + 1;
        end
    end

    a_credits: assert property (@(posedge clk) disable iff (rst)
        outstanding <= QUEUE_DEPTH)
        else begin $error("more requests outstanding than queue entries"); fail_count++; end

    a_act_to_rw: assert property (@(posedge clk) disable iff (rst)
        pins.cmd == CMD_ACTIVE |=> (pins.cmd != CMD_READ && pins.cmd != CMD_WRITE)[*(T_RCD-1)])
        else begin $error("read or write too soon after ACTIVE"); fail_count++; end

    a_pre_to_act: assert property (@(posedge clk) disable iff (rst)
        pins.cmd == CMD_PRECHARGE |=>
            (pins.cmd != CMD_ACTIVE && pins.cmd != CMD_REFRESH)[*(T_RP-1)])
        else begin $error("ACTIVE or REFRESH too soon after PRECHARGE"); fail_count++; end

    a_ref_quiet: assert property (@(posedge clk) disable iff (rst)
        pins.cmd == CMD_REFRESH |=> (pins.cmd == CMD_NOP)[*(T_RFC-1)])
        else begin $error("command issued during refresh cycle time"); fail_count++; end

    a_ref_interval: assert property (@(posedge clk) disable iff (rst)
        since_refresh < REFRESH_INTERVAL + 24)
        else begin $error("refresh interval exceeded"); fail_count++; end

    // refresh must follow a precharge of all banks
    a_ref_after_pre: assert property (@(posedge clk) disable iff (rst)
        pins.cmd == CMD_REFRESH |->
            $past(pins.cmd, T_RP) == CMD_PRECHARGE && $past(pins.a[AP_BIT], T_RP))
        else begin $error("REFRESH without a prior precharge of all banks"); fail_count++; end

    a_reset_quiet: assert property (@(posedge clk)
        warm && ($past(rst) || $past(rst, 2)) |->
            pins.cmd == CMD_NOP && !rd_valid && !credit_return && !pins.dq_oe)
        else begin $error("outputs active around reset"); fail_count++; end

    // cke low through reset and one cycle after, then high
    a_cke_after_reset: assert property (@(posedge clk)
        warm |-> pins.cke == !$past(rst))
        else begin $error("clock enable wrong around reset"); fail_count++; end

    a_oe_with_write: assert property (@(posedge clk) disable iff (rst)
        pins.dq_oe |-> pins.cmd == CMD_WRITE)
        else begin $error("data driven without a WRITE command"); fail_count++; end

endmodule

bind sdram_ctrl sdram_checker i_checker (
    .clk           (clk),
    .rst           (rst),
    .req_valid     (req_valid),
    .credit_return (credit_return),
    .rd_valid      (rd_valid),
    .pins          (pins)
);

// File: verification/sdram_model.sv
`timescale 1ns/10ps

module sdram_model import sdram_pkg::*; (
    input  logic        clk,
    input  sdram_pins_t pins,
    output sdram_word_t dqi
);

    sdram_word_t mem [user_addr_t];     // only written words are stored
    row_addr_t   active_row [4];
    sdram_word_t rd_pipe [CAS_LATENCY] = '{default: '0};

    // unwritten words read back as a pattern of their own address
    function automatic sdram_word_t fill_word(input user_addr_t addr);
        return {addr[8:0] ^ 9'h1a5, addr};
    endfunction

    always @(posedge clk) begin
        user_addr_t addr;
        addr = {active_row[pins.ba], pins.ba, pins.a[9:2]};
        case (pins.cmd)
            CMD_ACTIVE: begin
                active_row[pins.ba] = pins.a;
            end
            CMD_WRITE: begin
                if (pins.dq_oe) begin
                    mem[addr] = pins.dq_out;
                end
            end
            default: begin
            end
        endcase
        if (pins.cmd == CMD_READ) begin
            rd_pipe[0] <= mem.exists(addr) ? mem[addr] : fill_word(addr);
        end else begin
            rd_pipe[0] <= 'x;
        end
        for (int i = 1; i < CAS_LATENCY; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    assign dqi = rd_pipe[CAS_LATENCY-1];    // valid CAS_LATENCY cycles after READ

endmodule

// File: verification/tb_sdram_ctrl.sv
`timescale 1ns/10ps

module tb_sdram_ctrl import sdram_pkg::*; ();

    localparam int RUN_CYCLES  = 3400;  // covers four refresh intervals
    localparam int DRAIN_LIMIT = 200;

    logic        clk;
    logic        rst;
    logic        req_valid;
    sdram_req_t  req;
    logic        credit_return;
    sdram_word_t rd_data;
    logic        rd_valid;
    sdram_pins_t pins;
    sdram_word_t sdram_dqi;

    logic [31:0] lfsr;
    int          credits_used;
    int          credits_back;
    int          reads_checked;
    sdram_word_t shadow [user_addr_t];
    sdram_word_t expected [$];          // read results in request order

    sdram_ctrl i_dut (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req           (req),
        .credit_return (credit_return),
        .rd_data       (rd_data),
        .rd_valid      (rd_valid),
        .pins          (pins),
        .sdram_dqi     (sdram_dqi)
    );

    sdram_model i_sdram (
        .clk  (clk),
        .pins (pins),
        .dqi  (sdram_dqi)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    function automatic sdram_word_t fill_word(input user_addr_t addr);
        return {addr[8:0] ^ 9'h1a5, addr};
    endfunction

    // galois lfsr, one step per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return bits;
    endfunction

    task automatic send_request();
        sdram_req_t r;
        logic [1:0] row_sel;
        bank_addr_t bank;
        logic [2:0] col;
        r.write = take_bits(1) != 0;
        row_sel = 2'(take_bits(2));     // four rows per bank, plenty of conflicts
        bank    = 2'(take_bits(2));
        col     = 3'(take_bits(3));
        r.addr  = {11'h1b3, row_sel, bank, 5'h0a, col};
        r.data  = take_bits(32);
        if (r.write) begin
            shadow[r.addr] = r.data;
        end else begin
            expected.push_back(shadow.exists(r.addr) ? shadow[r.addr] : fill_word(r.addr));
        end
        req          <= r;
        req_valid    <= 1'b1;
        credits_used++;
    endtask

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        sdram_word_t exp_word;
        if (!rst && credit_return) begin
            credits_back++;
        end
        if (!rst && rd_valid) begin
            assert (expected.size() != 0)
                else stop_on_error("rd_valid pulsed with no read outstanding");
            exp_word = expected.pop_front();
            assert (rd_data == exp_word)
                else stop_on_error($sformatf("ERR %0t rd_data got %h expected %h",
                                             $time, rd_data, exp_word));
            reads_checked++;
        end
        if (i_dut.i_checker.fail_count != 0) begin
            stop_on_error("bound checker reported a protocol violation");
        end
    end

    initial begin
        logic go;
        int   wait_cnt;
        lfsr          = 32'h1506_9f70;
        credits_used  = 0;
        credits_back  = 0;
        reads_checked = 0;
        rst           = 1'b1;
        req_valid     = 1'b0;
        req           = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
            @(posedge clk);
            go = take_bits(2) != 0;     // about three requests in four cycles
            if (go && (credits_used - credits_back < QUEUE_DEPTH)) begin
                send_request();
            end else begin
                req_valid <= 1'b0;
            end
        end
        @(posedge clk);
        req_valid <= 1'b0;

        wait_cnt = 0;
        while (credits_back != credits_used && wait_cnt < DRAIN_LIMIT) begin
            @(posedge clk);
            wait_cnt++;
        end
        assert (credits_back == credits_used)
            else stop_on_error($sformatf("ERR %0t credit_return got %0d expected %0d",
                                         $time, credits_back, credits_used));

        wait_cnt = 0;
        while (expected.size() != 0 && wait_cnt < DRAIN_LIMIT) begin
            @(posedge clk);
            wait_cnt++;
        end
        assert (expected.size() == 0)
            else stop_on_error("timed out waiting for outstanding read data");
        assert (reads_checked > 0)
            else stop_on_error("no read data was ever returned");

        if (i_dut.i_checker.fail_count != 0) begin
            stop_on_error("bound checker reported a protocol violation");
        end else begin
            $display("Verification passed");
        end
        $finish;
    end

endmodule
